// ==== filelist.f ====
design/audio_pkg.sv
design/stream_pkg.sv
design/playback_buffer.sv
design/i2s_transmitter.sv
design/i2s_receiver.sv
design/record_framer.sv
design/audio_unit_top.sv
test/tb_clock_gen.sv
test/tb_audio_unit.sv

// ==== Bender.yml ====
package:
  name: audio_unit

sources:
  - design/audio_pkg.sv
  - design/stream_pkg.sv
  - design/playback_buffer.sv
  - design/i2s_transmitter.sv
  - design/i2s_receiver.sv
  - design/record_framer.sv
  - design/audio_unit_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_audio_unit.sv

// ==== test/tb_audio_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_audio_unit;

  localparam logic [31:0] MASK = 32'hffff_ff00;  // Top 24 bits kept

  logic ac_bclk, locked, ac_pblrc, ac_reclrc, ac_recdat, test_mode;
  logic s_tvalid, s_tready, m_tvalid, m_tlast, m_tready, ac_pbdat, almost_empty;
  logic [3:0] heartbeat, hb_m;
  audio_pkg::frame_t s_tdata, m_tdata, rec_cur, pend, mdata, dec, f;
  audio_pkg::frame_t wq[$], expq[$];              // Buffered and expected playback
  stream_pkg::status_t status, status_m;
  logic [31:0] seed = 32'h9775eda4, r, tone;
  int p, fr_cnt, pos, tone_cnt, played_m, under_m, beats, drops, ready_mode;
  bit wrapped, armed, pend_valid, mv, mlast, wr_on, tm_req, tone_hi = 1, accept;

  tb_clock_gen u_clk (.ac_bclk(ac_bclk), .locked(locked));

  audio_unit_top #(.WORD_BITS(24), .FIFO_DEPTH(8), .FRAME_LEN(4), .TONE_HALF_FRAMES(3))
  u_audio_unit_top (.*);

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;   // LCG step
    return seed;
  endfunction

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////////////////
  // Codec and reference model stepped on every bit clock
  always @(posedge ac_bclk) if (locked) begin
    p = (p == 63) ? 0 : p + 1;
    // Checks on pre-edge outputs
    assert (m_tvalid == mv)
      else report_failure($sformatf("Error: m_tvalid %h expected %h", m_tvalid, mv));
    if (mv) begin
      assert (m_tdata == mdata)
        else report_failure($sformatf("Error: m_tdata %h expected %h", m_tdata, mdata));
      assert (m_tlast == mlast)
        else report_failure($sformatf("Error: m_tlast %h expected %h", m_tlast, mlast));
    end
    assert (s_tready == (wq.size() < 8))
      else report_failure($sformatf("Error: s_tready %h, level %h", s_tready, wq.size()));
    assert (almost_empty == (wq.size() < 4))
      else report_failure($sformatf("Error: almost_empty %h, level %h", almost_empty, wq.size()));
    // Frame clock shared by both directions
    ac_pblrc  <= p >= 32;
    ac_reclrc <= p >= 32;
    if (p > 0 && p < 32)  ac_recdat <= rec_cur.left[32-p];
    else if (p > 32)      ac_recdat <= rec_cur.right[64-p];
    else                  ac_recdat <= 1'b0;
    if (p == 0) begin
      if (armed) begin
        pend       = '{left: rec_cur.left & MASK, right: rec_cur.right & MASK};
        pend_valid = 1;                          // Completed record frame
      end
      rec_cur = {next_rand(), next_rand()};
      armed   = 1;
      wrapped = 1;
      fr_cnt++;
    end
    // Record framer model accepts or drops at rec_valid
    if (mv && m_tready) beats++;
    accept = (p == 3) && pend_valid && (!mv || m_tready);
    if (p == 3 && pend_valid && !accept) drops++;
    if (p == 3) pend_valid = 0;
    if (accept) begin
      mdata = pend;
      mlast = (pos == 3);
      pos   = (pos + 1) % 4;
      mv    = 1;
    end else if (m_tready) mv = 0;
    r = next_rand();
    m_tready <= (ready_mode == 0) ? 1'b1 : (ready_mode == 1) ? r[0] : 1'b0;
    // Playback model follows the left start one edge after the fall
    if (p == 1 && wrapped) begin
      tone = tone_hi ? audio_pkg::TONE_HIGH : audio_pkg::TONE_LOW;
      if (test_mode) f = {tone, tone};
      else if (wq.size() > 0) begin
        f = wq.pop_front();
        played_m++;
      end else begin
        f = '0;                                  // Underrun frame
        under_m++;
      end
      expq.push_back(audio_pkg::frame_t'{left: f.left & MASK, right: f.right & MASK});
      tone_cnt++;
      if (tone_cnt == 3) begin
        tone_cnt = 0;
        tone_hi  = !tone_hi;
      end
    end
    if (s_tvalid && s_tready) wq.push_back(s_tdata);
    if (!s_tvalid || s_tready) begin             // Hold until taken
      s_tvalid <= wr_on && (r[3:2] != 2'b00);
      s_tdata  <= {next_rand(), next_rand()};
    end
    test_mode <= tm_req;
    // Decode ac_pbdat with bit k read at p == k + 2
    if (p == 1) dec = '0;
    if (p >= 2 && p <= 33)  dec.left[33-p]  = ac_pbdat;
    if (p >= 34 && p <= 63) dec.right[65-p] = ac_pbdat;
    if (p == 63 && expq.size() > 0) begin
      f = expq.pop_front();
      assert (dec == f)
        else report_failure($sformatf("Error: ac_pbdat frame %h expected %h", dec, f));
    end
  end

  task automatic wait_frames(int n);
    int target;
    int t;
    target = fr_cnt + n;
    for (t = 0; t < n * 64 + 200 && fr_cnt < target; t++) @(negedge ac_bclk);
    if (fr_cnt < target) report_failure("Timed out waiting for I2S frames");
  endtask

  task automatic wait_full();
    int t;
    for (t = 0; t < 3000 && s_tready; t++) @(negedge ac_bclk);
    if (s_tready) report_failure("Timed out waiting for the playback buffer to fill");
  endtask

  initial begin
    int t;
    {ac_pblrc, ac_reclrc, ac_recdat, test_mode, s_tvalid} = '0;
    s_tdata  = '0;
    m_tready = 1'b1;
    for (t = 0; t < 20 && !locked; t++) @(posedge ac_bclk);
    if (!locked) report_failure("Timed out waiting for reset release");
    @(negedge ac_bclk);
    assert (s_tready && !m_tvalid && !m_tlast && !ac_pbdat && almost_empty && status == '0)
      else report_failure($sformatf(
        "Error: reset s_tready %h m_tvalid %h m_tlast %h ac_pbdat %h almost_empty %h status %h",
        s_tready, m_tvalid, m_tlast, ac_pbdat, almost_empty, status));
    wr_on = 1;                                   // Playback with random gaps
    wait_full();
    wait_frames(10);
    wr_on = 0;                                   // Drain into underruns
    wait_frames(12);
    if (under_m == 0) report_failure("No underrun frames were produced");
    wr_on = 1;
    wait_full();
    wr_on  = 0;
    tm_req = 1;                                  // Tone while the buffer holds
    wait_frames(8);
    tm_req = 0;
    ready_mode = 2;                              // Record back-pressure
    wait_frames(4);
    ready_mode = 1;
    wait_frames(6);
    ready_mode = 0;
    wait_frames(12);
    @(negedge ac_bclk);
    status_m = '{played: 16'(played_m), underruns: 16'(under_m),
                 recorded: 16'(beats), overruns: 16'(drops)};
    hb_m = {status_m.played[4], status_m.underruns[4], status_m.recorded[4],
            status_m.overruns[4]};
    assert (status == status_m)
      else report_failure($sformatf("Error: status %h expected %h", status, status_m));
    assert (heartbeat == hb_m)
      else report_failure($sformatf("Error: heartbeat %h expected %h", heartbeat, hb_m));
    if (drops == 0) begin
      report_failure("No record overruns were produced");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Codec bit clock and PLL lock stand-in
module tb_clock_gen (
  output logic ac_bclk,
  output logic locked
);

  initial begin
    ac_bclk = 1'b0;
    locked  = 1'b0;                      // Reset held from time zero
    repeat (3) @(posedge ac_bclk);
    locked <= 1'b1;
  end

  always #2 ac_bclk = ~ac_bclk;         // 4 ns period

endmodule

`default_nettype wire

// ==== design/audio_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// I2S audio unit on the codec bit clock
module audio_unit_top #(
  parameter int WORD_BITS          = 24,
  parameter int FIFO_DEPTH         = 16,
  parameter int ALMOST_EMPTY_LEVEL = 4,
  parameter int FRAME_LEN          = 16,
  parameter int TONE_HALF_FRAMES   = 128
) (
  input  wire                    ac_bclk,
  input  wire                    locked,     // Async reset, active low
  input  wire                    ac_pblrc,
  output logic                   ac_pbdat,
  input  wire                    ac_reclrc,
  input  wire                    ac_recdat,
  input  wire                    test_mode,
  input  wire                    s_tvalid,
  input  wire audio_pkg::frame_t s_tdata,
  output logic                   s_tready,
  output logic                   m_tvalid,
  output audio_pkg::frame_t      m_tdata,
  output logic                   m_tlast,
  input  wire                    m_tready,
  output logic                   almost_empty,
  output stream_pkg::status_t    status,
  output logic [3:0]             heartbeat
);

  logic               play_valid, play_ready, underrun, rec_valid;
  audio_pkg::frame_t  play_frame, rec_frame;
  stream_pkg::count_t played_cnt, underrun_cnt, recorded_cnt, overrun_cnt;

  ////////////////////////////////////////////////////////////
  // Playback: stream -> buffer -> serializer
  playback_buffer #(.FIFO_DEPTH(FIFO_DEPTH), .ALMOST_EMPTY_LEVEL(ALMOST_EMPTY_LEVEL))
  u_playback_buffer (
    .ac_bclk(ac_bclk), .locked(locked),
    .s_tvalid(s_tvalid), .s_tdata(s_tdata), .s_tready(s_tready),
    .play_valid(play_valid), .play_frame(play_frame), .play_ready(play_ready),
    .underrun(underrun), .almost_empty(almost_empty),
    .played(played_cnt), .underruns(underrun_cnt)
  );

  i2s_transmitter #(.WORD_BITS(WORD_BITS), .TONE_HALF_FRAMES(TONE_HALF_FRAMES))
  u_i2s_transmitter (
    .ac_bclk(ac_bclk), .locked(locked), .ac_pblrc(ac_pblrc), .ac_pbdat(ac_pbdat),
    .test_mode(test_mode), .play_valid(play_valid), .play_frame(play_frame),
    .play_ready(play_ready), .underrun(underrun)
  );

  ////////////////////////////////////////////////////////////
  // Record: deserializer -> output register -> stream
  i2s_receiver #(.WORD_BITS(WORD_BITS)) u_i2s_receiver (
    .ac_bclk(ac_bclk), .locked(locked), .ac_reclrc(ac_reclrc), .ac_recdat(ac_recdat),
    .rec_valid(rec_valid), .rec_frame(rec_frame)
  );

  record_framer #(.FRAME_LEN(FRAME_LEN)) u_record_framer (
    .ac_bclk(ac_bclk), .locked(locked), .rec_valid(rec_valid), .rec_frame(rec_frame),
    .m_tvalid(m_tvalid), .m_tdata(m_tdata), .m_tlast(m_tlast), .m_tready(m_tready),
    .recorded(recorded_cnt), .overruns(overrun_cnt)
  );

  // Statistics and a slow toggle per counter
  assign status = '{played: played_cnt, underruns: underrun_cnt,
                    recorded: recorded_cnt, overruns: overrun_cnt};
  assign heartbeat = {played_cnt[4], underrun_cnt[4], recorded_cnt[4], overrun_cnt[4]};

endmodule

`default_nettype wire

// ==== design/record_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Record output stage, one-beat register with tlast grouping
module record_framer #(
  parameter int FRAME_LEN = 16  // Beats per tlast group
) (
  input  wire                    ac_bclk,
  input  wire                    locked,
  input  wire                    rec_valid,
  input  wire audio_pkg::frame_t rec_frame,
  output logic                   m_tvalid,
  output audio_pkg::frame_t      m_tdata,
  output logic                   m_tlast,
  input  wire                    m_tready,
  output stream_pkg::count_t     recorded,
  output stream_pkg::count_t     overruns
);

  typedef logic [$clog2(FRAME_LEN + 1)-1:0] pos_t;

  stream_pkg::rec_beat_t beat_q;
  pos_t                  pos_q;   // Position within tlast group
  logic                  accept;

  // Take a frame into an empty or draining register
  assign accept  = rec_valid && (!m_tvalid || m_tready);
  assign m_tdata = beat_q.frame;
  assign m_tlast = beat_q.last;

  always_ff @(posedge ac_bclk or negedge locked) begin
    if (!locked) begin
      beat_q   <= '0;
      m_tvalid <= 1'b0;
      pos_q    <= '0;
      recorded <= '0;
      overruns <= '0;
    end else begin
      if (accept) begin
        beat_q.frame <= rec_frame;
        beat_q.last  <= pos_q == pos_t'(FRAME_LEN - 1);
        pos_q        <= (pos_q == pos_t'(FRAME_LEN - 1)) ? '0 : pos_q + 1'b1;
        m_tvalid     <= 1'b1;
      end else if (m_tready) begin
        m_tvalid <= 1'b0;                    // Beat taken
      end
      if (m_tvalid && m_tready)  recorded <= recorded + 1'b1;
      if (rec_valid && !accept)  overruns <= overruns + 1'b1;  // Dropped
    end
  end

  a_hold_stall: assert property (@(posedge ac_bclk) disable iff (!locked)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast));

endmodule

`default_nettype wire

// ==== design/i2s_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

// I2S record deserializer, emits one stereo frame per falling reclrc
module i2s_receiver #(
  parameter int WORD_BITS = 24  // 16, 20, 24 or 32
) (
  input  wire               ac_bclk,
  input  wire               locked,
  input  wire               ac_reclrc,
  input  wire               ac_recdat,
  output logic              rec_valid,
  output audio_pkg::frame_t rec_frame
);

  typedef logic [5:0] bit_cnt_t;  // Counts up to 32

  logic               lrc_q;       // Registered reclrc
  logic               lrc_edge;
  bit_cnt_t           bit_cnt_q;   // Saturates at WORD_BITS
  audio_pkg::sample_t sreg_q;      // Bits land MSB-aligned
  audio_pkg::sample_t cap_word;    // Word incl. this cycle's bit
  audio_pkg::sample_t left_q;
  logic               chan_ok_q;   // Channel began at a seen edge
  logic               left_ok_q;   // Full left channel held
  logic               emit_q;

  assign lrc_edge = lrc_q != ac_reclrc;

  // Bit k of a channel is sampled two edges after the lrc change plus k
  always_comb begin
    cap_word = sreg_q;
    if (bit_cnt_q < bit_cnt_t'(WORD_BITS)) cap_word[5'(31 - bit_cnt_q)] = ac_recdat;
  end

  ////////////////////////////////////////////////////////////
  // Data path
  always_ff @(posedge ac_bclk) begin
    if (lrc_edge) begin
      sreg_q <= '0;                          // Zero-fill below WORD_BITS
      if (ac_reclrc) begin
        left_q <= cap_word;                  // Left channel ends
      end else begin
        rec_frame.left  <= left_q;
        rec_frame.right <= cap_word;         // Right channel ends
      end
    end else begin
      sreg_q <= cap_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // Control
  always_ff @(posedge ac_bclk or negedge locked) begin
    if (!locked) begin
      lrc_q     <= 1'b0;
      bit_cnt_q <= bit_cnt_t'(WORD_BITS);   // Idle until first edge
      chan_ok_q <= 1'b0;
      left_ok_q <= 1'b0;
      emit_q    <= 1'b0;
      rec_valid <= 1'b0;
    end else begin
      lrc_q     <= ac_reclrc;
      rec_valid <= emit_q;                   // Second edge after lrc change
      emit_q    <= 1'b0;
      if (lrc_edge) begin
        bit_cnt_q <= '0;
        chan_ok_q <= 1'b1;
        if (ac_reclrc) left_ok_q <= chan_ok_q;
        else emit_q <= left_ok_q && chan_ok_q;  // Full frame seen
      end else if (bit_cnt_q < bit_cnt_t'(WORD_BITS)) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/i2s_transmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

// I2S playback serializer with a one-bit delay after each pblrc edge
module i2s_transmitter #(
  parameter int WORD_BITS        = 24,   // 16, 20, 24 or 32
  parameter int TONE_HALF_FRAMES = 128
) (
  input  wire                    ac_bclk,
  input  wire                    locked,
  input  wire                    ac_pblrc,
  output logic                   ac_pbdat,
  input  wire                    test_mode,
  input  wire                    play_valid,
  input  wire audio_pkg::frame_t play_frame,
  output logic                   play_ready,
  output logic                   underrun
);

  // Keeps the top WORD_BITS bits
  localparam audio_pkg::sample_t WORD_MASK = ~(32'hffff_ffff >> WORD_BITS);

  typedef enum logic [1:0] {ST_IDLE, ST_LEFT, ST_RIGHT} chan_state_e;
  typedef logic [$clog2(TONE_HALF_FRAMES + 1)-1:0] tone_cnt_t;

  chan_state_e        state_q;
  logic               lrc_q;                   // Registered pblrc
  logic               left_start, right_start;
  audio_pkg::sample_t sreg_q;                  // Output shifter
  audio_pkg::sample_t right_q;                 // Right sample waiting
  audio_pkg::sample_t tone_level, left_word, right_word;
  tone_cnt_t          tone_cnt_q;
  logic               tone_high_q;

  assign left_start  = lrc_q && !ac_pblrc;    // Falling pblrc
  assign right_start = !lrc_q && ac_pblrc;    // Rising pblrc
  assign play_ready  = left_start && !test_mode;
  assign underrun    = play_ready && !play_valid;
  assign tone_level  = tone_high_q ? audio_pkg::TONE_HIGH : audio_pkg::TONE_LOW;
  assign ac_pbdat    = sreg_q[31];            // MSB first

  // Source select between tone, buffered frame and silence
  always_comb begin
    left_word  = '0;
    right_word = '0;
    if (test_mode) begin
      left_word  = tone_level;
      right_word = tone_level;
    end else if (play_valid) begin
      left_word  = play_frame.left;
      right_word = play_frame.right;
    end
  end

  always_ff @(posedge ac_bclk) begin
    if (left_start) right_q <= right_word & WORD_MASK;
  end

  always_ff @(posedge ac_bclk or negedge locked) begin
    if (!locked) begin
      lrc_q       <= 1'b0;
      state_q     <= ST_IDLE;
      sreg_q      <= '0;
      tone_cnt_q  <= '0;
      tone_high_q <= 1'b1;                     // Tone starts high
    end else begin
      lrc_q <= ac_pblrc;
      if (left_start) begin
        state_q <= ST_LEFT;
        sreg_q  <= left_word & WORD_MASK;
        if (tone_cnt_q == tone_cnt_t'(TONE_HALF_FRAMES - 1)) begin
          tone_cnt_q  <= '0;
          tone_high_q <= ~tone_high_q;       // Half period done
        end else begin
          tone_cnt_q <= tone_cnt_q + 1'b1;
        end
      end else if (right_start) begin
        // Right only follows a loaded left
        state_q <= (state_q == ST_LEFT) ? ST_RIGHT : ST_IDLE;
        sreg_q  <= (state_q == ST_LEFT) ? right_q : '0;
      end else begin
        sreg_q <= {sreg_q[30:0], 1'b0};     // Zeros past bit 32
      end
    end
  end

  // Nothing below the word length is ever loaded or shifted out
  a_word_masked: assert property (@(posedge ac_bclk) disable iff (!locked)
    (sreg_q & ~WORD_MASK) == '0);

endmodule

`default_nettype wire

// ==== design/playback_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Playback FIFO between the input stream and the I2S transmitter
module playback_buffer #(
  parameter int FIFO_DEPTH         = 16,  // Power of two
  parameter int ALMOST_EMPTY_LEVEL = 4
) (
  input  wire                ac_bclk,
  input  wire                locked,
  input  wire                s_tvalid,
  input  wire audio_pkg::frame_t s_tdata,
  output logic               s_tready,
  output logic               play_valid,
  output audio_pkg::frame_t  play_frame,
  input  wire                play_ready,   // Pulse at each left start
  input  wire                underrun,     // From transmitter
  output logic               almost_empty,
  output stream_pkg::count_t played,
  output stream_pkg::count_t underruns
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [LVL_W-1:0] level_t;

  audio_pkg::frame_t mem [FIFO_DEPTH];  // Frame storage
  ptr_t   wr_ptr_q, rd_ptr_q;           // Wrap naturally
  level_t level_q;                      // Frames held
  logic   wr_en, rd_en;

  assign s_tready     = level_q != level_t'(FIFO_DEPTH);  // Not full
  assign play_valid   = level_q != '0;
  assign play_frame   = mem[rd_ptr_q];                    // First-word fall-through
  assign wr_en        = s_tvalid && s_tready;
  assign rd_en        = play_ready && play_valid;
  assign almost_empty = level_q < level_t'(ALMOST_EMPTY_LEVEL);

  always_ff @(posedge ac_bclk) begin
    if (wr_en) mem[wr_ptr_q] <= s_tdata;
  end

  always_ff @(posedge ac_bclk or negedge locked) begin
    if (!locked) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      level_q   <= '0;
      played    <= '0;
      underruns <= '0;
    end else begin
      if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;      // Idle or both
      endcase
      if (rd_en)    played    <= played + 1'b1;
      if (underrun) underruns <= underruns + 1'b1;
    end
  end

  // Level agrees with the pointer distance and never passes full
  a_no_write_full: assert property (@(posedge ac_bclk) disable iff (!locked)
    (level_q <= level_t'(FIFO_DEPTH)) && (ptr_t'(wr_ptr_q - rd_ptr_q) == ptr_t'(level_q)));
  // A request on an empty buffer must come back as an underrun
  a_no_read_empty: assert property (@(posedge ac_bclk) disable iff (!locked)
    play_ready && (level_q == '0) |-> underrun);

endmodule

`default_nettype wire

// ==== design/stream_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// Stream beats and status counters
////////////////////////////////////////////////////////////

package stream_pkg;

  typedef logic [15:0] count_t;  // All statistics counters

  // Record stream beat
  typedef struct packed {
    audio_pkg::frame_t frame;
    logic              last;   // Ends a record frame group
  } rec_beat_t;

  // Status word, played in the top 16 bits
  typedef struct packed {
    count_t played;
    count_t underruns;
    count_t recorded;
    count_t overruns;
  } status_t;

endpackage

`default_nettype wire

// ==== design/audio_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// Audio sample and stereo frame definitions
////////////////////////////////////////////////////////////

package audio_pkg;

  // One channel, MSB-aligned
  // Only the top WORD_BITS bits carry audio, the rest are zero
  typedef logic [31:0] sample_t;

  // Stereo frame, same layout as the 64-bit stream word
  typedef struct packed {
    sample_t left;   // Upper half
    sample_t right;  // Lower half
  } frame_t;

  // Square-wave test tone levels
  localparam sample_t TONE_HIGH = 32'h0000_1fff;
  localparam sample_t TONE_LOW  = 32'h0000_0000;

endpackage

`default_nettype wire
